/* logic/blackjack_pkg.sv */
/*
  Shared card, sum, phase and outcome types for the blackjack game.
  Cards are 4-bit codes 1..13; face cards count ten and an ace counts one.
  sum_t is 6 bits, so a hand holds at most six tens before it wraps.
  Segment patterns are active low, ordered a (MSB) to g (LSB).
*/
package blackjack_pkg;

    typedef logic [3:0] card_t;
    typedef logic [5:0] sum_t;
    typedef logic [6:0] seg_t;

    typedef enum logic [1:0] {PH_IDLE, PH_DEAL, PH_PLAY, PH_DONE} phase_t;
    typedef enum logic [1:0] {OC_NONE, OC_PLAYER, OC_HOUSE, OC_DRAW} outcome_t;

    localparam sum_t BUST_LIMIT  = 6'd21;
    // House keeps drawing below this sum
    localparam sum_t HOUSE_STAND = 6'd17;

    // Low part of the LFSR load word, seed sits above it
    localparam logic [9:0] LFSR_FILL = 10'b1011001101;

    // Letter codes above the card range, for the hand tag digit
    localparam card_t CODE_H = 4'd14;
    localparam card_t CODE_P = 4'd15;

    // Card value, code capped at ten
    function automatic sum_t card_value(input card_t c);
        return (c > 4'd10) ? sum_t'(10) : sum_t'(c);
    endfunction

    // Code to digit pattern, blank for an empty slot
    function automatic seg_t seg_of(input card_t c);
        case (c)
            4'd1:    return 7'b0001000;  // A
            4'd2:    return 7'b0010010;
            4'd3:    return 7'b0000110;
            4'd4:    return 7'b1001100;
            4'd5:    return 7'b0100100;
            4'd6:    return 7'b0100000;
            4'd7:    return 7'b0001111;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0000100;
            4'd10:   return 7'b0000001;  // shown as 0
            4'd11:   return 7'b1000011;  // J
            4'd12:   return 7'b0001100;  // q
            4'd13:   return 7'b0101000;  // K approximation
            CODE_H:  return 7'b1001000;
            CODE_P:  return 7'b0011000;
            default: return 7'b1111111;
        endcase
    endfunction

endpackage

/* logic/card_if.sv */
/*
  Card request channel between the game controller and the card source.
  req only while ready is high; ready drops the next cycle and rises
  again once card holds a new code in 1..13. load reseeds the source.
*/
`timescale 1ns/10ps

interface card_if;
    import blackjack_pkg::*;

    // Strobes from the controller
    logic  load;
    logic  req;
    // Source status and card code
    logic  ready;
    card_t card;

    modport ctrl (
        output load,
        output req,
        input  ready,
        input  card
    );

    modport src (
        input  load,
        input  req,
        output ready,
        output card
    );

endinterface

/* logic/card_source.sv */
/*
  Pseudo-random card source, a 16-bit Fibonacci LFSR loaded from the seed.
  Draws are independent, so duplicate cards are possible and nothing runs out.
  Latency per card varies; codes 0, 14 and 15 are rejected and stepped past.
  card is undefined until the first draw after reset.
*/
`timescale 1ns/10ps

module card_source (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] seed,
    card_if.src        cif
);
    import blackjack_pkg::*;

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    card_t       nibble;
    logic        nibble_ok;
    logic        ready_q;
    card_t       card_q;

    // Taps 16,14,13,11, maximal length
    assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

    // Candidate card from the low nibble of the next state
    assign nibble    = lfsr_next[3:0];
    assign nibble_ok = (nibble != 4'd0) && (nibble <= 4'd13);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr    <= {6'd0, LFSR_FILL};
            ready_q <= 1'b1;
        end else if (cif.load) begin
            lfsr    <= {seed, LFSR_FILL};
            ready_q <= 1'b1;
        end else if (cif.req) begin
            // Start a draw, ready drops next cycle
            lfsr    <= lfsr_next;
            ready_q <= 1'b0;
        end else if (!ready_q) begin
            lfsr <= lfsr_next;
            if (nibble_ok) begin
                ready_q <= 1'b1;
            end
        end
    end

    // Card code only changes when a draw completes
    always_ff @(posedge clk) begin
        if (!ready_q && !cif.load && !cif.req && nibble_ok) begin
            card_q <= nibble;
        end
    end

    assign cif.ready = ready_q;
    assign cif.card  = card_q;

endmodule

/* logic/hand_store.sv */
/*
  One hand: card slots, card count and running value sum.
  Slots fill from index 0; an add on a full hand is dropped.
  Outputs reflect an add or clear on the following cycle.
*/
`timescale 1ns/10ps

module hand_store #(
    parameter int  MAX_CARDS = 5,
    localparam int CNT_W     = $clog2(MAX_CARDS + 1)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 add,
    input  blackjack_pkg::card_t card,
    output blackjack_pkg::card_t cards [MAX_CARDS],
    output logic [CNT_W-1:0]     count,
    output blackjack_pkg::sum_t  sum
);
    import blackjack_pkg::*;

    logic full;

    assign full = (count == CNT_W'(MAX_CARDS));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // Empty hand so the digits come up blank
            for (int i = 0; i < MAX_CARDS; i++) begin
                cards[i] <= '0;
            end
            count <= '0;
            sum   <= '0;
        end else if (clear) begin
            for (int i = 0; i < MAX_CARDS; i++) begin
                cards[i] <= '0;
            end
            count <= '0;
            sum   <= '0;
        end else if (add && !full) begin
            // Write into the next free slot
            for (int i = 0; i < MAX_CARDS; i++) begin
                if (CNT_W'(i) == count) begin
                    cards[i] <= card;
                end
            end
            count <= count + 1'b1;
            sum   <= sum + card_value(card);
        end
    end

endmodule

/* logic/game_ctrl.sv */
/*
  Game FSM: button release detect, deal, player turn, house turn, decision.
  Buttons are active low and act on release, one register stage deep.
  Deal order is player, house, player, house; the house plays after the
  player stands, reaches 21 or fills the hand. Begin works in idle or done only.
*/
`timescale 1ns/10ps

module game_ctrl #(
    parameter int  MAX_CARDS = 5,
    localparam int CNT_W     = $clog2(MAX_CARDS + 1)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     begin_n,
    input  logic                     hit_n,
    input  logic                     stand_n,
    input  blackjack_pkg::sum_t      player_sum,
    input  blackjack_pkg::sum_t      house_sum,
    input  logic [CNT_W-1:0]         player_count,
    input  logic [CNT_W-1:0]         house_count,
    card_if.ctrl                     cif,
    output logic                     player_clear,
    output logic                     player_add,
    output logic                     house_clear,
    output logic                     house_add,
    output blackjack_pkg::phase_t    phase,
    output blackjack_pkg::outcome_t  outcome
);
    import blackjack_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,    // waiting for begin
        S_LOAD,    // reseed the card source
        S_REQ,     // request a card once the source is ready
        S_WAIT,    // card in flight
        S_SETTLE,  // hand updated, act on the new sum
        S_PLAY,    // player turn
        S_HOUSE,   // house draws or the game is decided
        S_DONE
    } state_t;

    state_t     state;
    logic [2:0] begin_sr;
    logic [2:0] hit_sr;
    logic [2:0] stand_sr;
    logic       begin_rel;
    logic       hit_rel;
    logic       stand_rel;
    logic       start;
    logic       to_house;
    logic [1:0] deal_cnt;
    logic       card_in;

    // Input register plus one stage for the release edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            begin_sr <= '1;
            hit_sr   <= '1;
            stand_sr <= '1;
        end else begin
            begin_sr <= {begin_sr[1:0], begin_n};
            hit_sr   <= {hit_sr[1:0], hit_n};
            stand_sr <= {stand_sr[1:0], stand_n};
        end
    end

    // Released now, pressed a cycle before
    assign begin_rel = begin_sr[1] & ~begin_sr[2];
    assign hit_rel   = hit_sr[1] & ~hit_sr[2];
    assign stand_rel = stand_sr[1] & ~stand_sr[2];

    assign start   = begin_rel && (state == S_IDLE || state == S_DONE);
    assign card_in = (state == S_WAIT) && cif.ready;

    // Strobes decoded from state
    assign cif.load     = (state == S_LOAD);
    assign cif.req      = (state == S_REQ) && cif.ready;
    assign player_clear = start;
    assign house_clear  = start;
    assign player_add   = card_in && !to_house;
    assign house_add    = card_in && to_house;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= S_IDLE;
            phase    <= PH_IDLE;
            outcome  <= OC_NONE;
            to_house <= 1'b0;
            deal_cnt <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start) begin
                        phase    <= PH_DEAL;
                        outcome  <= OC_NONE;
                        to_house <= 1'b0;
                        deal_cnt <= '0;
                        state    <= S_LOAD;
                    end
                end
                S_LOAD: state <= S_REQ;
                S_REQ: begin
                    if (cif.ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (cif.ready) begin
                        state <= S_SETTLE;
                    end
                end
                S_SETTLE: begin
                    if (phase == PH_DEAL) begin
                        if (deal_cnt == 2'd3) begin
                            phase <= PH_PLAY;
                            state <= S_PLAY;
                        end else begin
                            deal_cnt <= deal_cnt + 2'd1;
                            to_house <= ~to_house;
                            state    <= S_REQ;
                        end
                    end else if (to_house) begin
                        state <= S_HOUSE;
                    end else if (player_sum > BUST_LIMIT) begin
                        // Player bust ends the game at once
                        outcome <= OC_HOUSE;
                        phase   <= PH_DONE;
                        state   <= S_DONE;
                    end else if (player_sum == BUST_LIMIT ||
                                 player_count == CNT_W'(MAX_CARDS)) begin
                        to_house <= 1'b1;
                        state    <= S_HOUSE;
                    end else begin
                        state <= S_PLAY;
                    end
                end
                S_PLAY: begin
                    if (hit_rel) begin
                        to_house <= 1'b0;
                        state    <= S_REQ;
                    end else if (stand_rel) begin
                        to_house <= 1'b1;
                        state    <= S_HOUSE;
                    end
                end
                S_HOUSE: begin
                    if (house_sum < HOUSE_STAND && house_count < CNT_W'(MAX_CARDS)) begin
                        state <= S_REQ;
                    end else begin
                        phase <= PH_DONE;
                        state <= S_DONE;
                        // House bust first, then plain comparison
                        if (house_sum > BUST_LIMIT || player_sum > house_sum) begin
                            outcome <= OC_PLAYER;
                        end else if (player_sum < house_sum) begin
                            outcome <= OC_HOUSE;
                        end else begin
                            outcome <= OC_DRAW;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* logic/hand_display.sv */
/*
  Six-digit hand view. hand_select low shows the player, high the house.
  Digits 0..4 carry the first five slots, digit 5 the P or H tag.
  Slots beyond MAX_CARDS stay blank. Purely combinational.
*/
`timescale 1ns/10ps

module hand_display #(
    parameter int MAX_CARDS = 5
) (
    input  logic                 hand_select,
    input  blackjack_pkg::card_t player_cards [MAX_CARDS],
    input  blackjack_pkg::card_t house_cards  [MAX_CARDS],
    output blackjack_pkg::seg_t  hand_seg     [6]
);
    import blackjack_pkg::*;

    localparam int CARD_DIGITS = 5;

    card_t shown [MAX_CARDS];

    // Hand mux
    always_comb begin
        for (int i = 0; i < MAX_CARDS; i++) begin
            shown[i] = hand_select ? house_cards[i] : player_cards[i];
        end
    end

    for (genvar d = 0; d < CARD_DIGITS; d++) begin : g_digit
        if (d < MAX_CARDS) begin : g_card
            assign hand_seg[d] = seg_of(shown[d]);
        end else begin : g_blank
            // No slot behind this digit
            assign hand_seg[d] = seg_of(4'd0);
        end
    end

    // Tag digit names the hand on view
    assign hand_seg[CARD_DIGITS] = seg_of(hand_select ? CODE_H : CODE_P);

endmodule

/* logic/blackjack_top.sv */
/*
  Blackjack top level, instances and wiring only.
  Buttons begin_n, hit_n and stand_n are active low, seed is read at begin.
  hand_seg[5] is the P/H tag, hand_seg[0..4] the cards in deal order.
*/
`timescale 1ns/10ps

module blackjack_top #(
    parameter int  MAX_CARDS = 5,
    localparam int CNT_W     = $clog2(MAX_CARDS + 1)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     begin_n,
    input  logic                     hit_n,
    input  logic                     stand_n,
    input  logic                     hand_select,
    input  logic [5:0]               seed,
    output blackjack_pkg::phase_t    phase,
    output blackjack_pkg::outcome_t  outcome,
    output blackjack_pkg::seg_t      hand_seg [6]
);
    import blackjack_pkg::*;

    card_if cif ();

    // Hand control
    logic             player_clear;
    logic             player_add;
    logic             house_clear;
    logic             house_add;
    // Hand state back to the controller and display
    card_t            player_cards [MAX_CARDS];
    card_t            house_cards  [MAX_CARDS];
    logic [CNT_W-1:0] player_count;
    logic [CNT_W-1:0] house_count;
    sum_t             player_sum;
    sum_t             house_sum;

    game_ctrl #(.MAX_CARDS(MAX_CARDS)) game_ctrl_i (
        .clk, .rst, .begin_n, .hit_n, .stand_n,
        .player_sum, .house_sum, .player_count, .house_count,
        .cif          (cif.ctrl),
        .player_clear, .player_add, .house_clear, .house_add,
        .phase, .outcome
    );

    card_source card_source_i (
        .clk, .rst, .seed,
        .cif (cif.src)
    );

    // Both hands latch the card currently held on the channel
    hand_store #(.MAX_CARDS(MAX_CARDS)) player_hand_i (
        .clk, .rst,
        .clear (player_clear),
        .add   (player_add),
        .card  (cif.card),
        .cards (player_cards),
        .count (player_count),
        .sum   (player_sum)
    );

    hand_store #(.MAX_CARDS(MAX_CARDS)) house_hand_i (
        .clk, .rst,
        .clear (house_clear),
        .add   (house_add),
        .card  (cif.card),
        .cards (house_cards),
        .count (house_count),
        .sum   (house_sum)
    );

    hand_display #(.MAX_CARDS(MAX_CARDS)) hand_display_i (
        .hand_select, .player_cards, .house_cards, .hand_seg
    );

endmodule

/* verification/blackjack_tests.svh */
/*
  Directed tests and scoring model, included in the blackjack_tb body.
  Model scores a card as its code capped at ten, ace as one.
  Digits are mapped back to codes through the package segment table.
*/
`ifndef BLACKJACK_TESTS_SVH
`define BLACKJACK_TESTS_SVH

function automatic int value_of(input int code);
    return (code > 10) ? 10 : code;
endfunction

// Inverse of the segment table, -1 for an unknown pattern
function automatic int decode_digit(input seg_t s);
    for (int c = 0; c < 16; c++) begin
        if (seg_of(card_t'(c)) == s) begin
            return c;
        end
    end
    return -1;
endfunction

function automatic outcome_t expected_outcome(input int ps, input int hs);
    if (ps > BUST_LIMIT) return OC_HOUSE;
    if (hs > BUST_LIMIT || ps > hs) return OC_PLAYER;
    if (ps < hs) return OC_HOUSE;
    return OC_DRAW;
endfunction

task automatic reset_dut();
    @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;
endtask

// Hold the button low two cycles, then release
task automatic press_button(input int which);
    @(posedge clk);
    #1;
    case (which)
        BTN_BEGIN: begin_n = 1'b0;
        BTN_HIT:   hit_n   = 1'b0;
        default:   stand_n = 1'b0;
    endcase
    repeat (2) @(posedge clk);
    #1;
    begin_n = 1'b1;
    hit_n   = 1'b1;
    stand_n = 1'b1;
endtask

task automatic wait_phase(input phase_t target, input string what);
    int n;
    n = 0;
    while (phase != target && n < STEP_LIMIT) begin
        @(posedge clk);
        #1;
        n++;
    end
    assert (phase == target) else begin
        $display("timed out waiting for %s", what);
        errors++;
    end
endtask

// Reads both hands off the digits, player first
task automatic read_hands();
    int   code;
    card_t tag;
    for (int h = 0; h < 2; h++) begin
        hand_select = (h == HOUSE);
        tag         = (h == HOUSE) ? CODE_H : CODE_P;
        #1;
        shown_count[h] = 0;
        shown_sum[h]   = 0;
        for (int i = 0; i < MAX_CARDS; i++) begin
            code = decode_digit(hand_seg[i]);
            shown_cards[h][i] = code;
            assert (code >= 0 && code <= 13) else begin
                $display("digit %0d of hand %0d shows no card, segments 'h%h", i, h, hand_seg[i]);
                errors++;
            end
            if (code > 0 && code <= 13) begin
                shown_count[h]++;
                shown_sum[h] += value_of(code);
            end
        end
        assert (hand_seg[5] == seg_of(tag)) else begin
            $display("mismatch hand_seg[5]: got 'h%h expected 'h%h", hand_seg[5], seg_of(tag));
            errors++;
        end
    end
    hand_select = 1'b0;
    #1;
endtask

task automatic deal_game(input logic [5:0] game_seed);
    @(posedge clk);
    #1;
    seed = game_seed;
    press_button(BTN_BEGIN);
    wait_phase(PH_PLAY, "the deal to finish");
endtask

// Every house draw after the deal must start below the stand value
task automatic check_house_play();
    int prefix;
    prefix = value_of(shown_cards[HOUSE][0]) + value_of(shown_cards[HOUSE][1]);
    for (int k = 2; k < shown_count[HOUSE]; k++) begin
        assert (prefix < HOUSE_STAND) else begin
            $display("house drew card %0d at sum %0d", k + 1, prefix);
            errors++;
        end
        prefix += value_of(shown_cards[HOUSE][k]);
    end
    assert (shown_sum[HOUSE] >= HOUSE_STAND || shown_count[HOUSE] == MAX_CARDS) else begin
        $display("house stopped early at sum %0d", shown_sum[HOUSE]);
        errors++;
    end
endtask

// Hits below hit_below, then stands, and scores the result
task automatic play_and_check(input logic [5:0] game_seed, input int hit_below);
    int prev;
    int n;
    outcome_t exp;
    deal_game(game_seed);
    read_hands();
    while (phase == PH_PLAY && shown_sum[PLAYER] < hit_below &&
           shown_count[PLAYER] < MAX_CARDS) begin
        prev = shown_count[PLAYER];
        press_button(BTN_HIT);
        n = 0;
        do begin
            @(posedge clk);
            #1;
            read_hands();
            n++;
        end while (shown_count[PLAYER] == prev && n < STEP_LIMIT);
        assert (shown_count[PLAYER] == prev + 1) else begin
            $display("hit did not add a card to the player hand");
            errors++;
            break;
        end
        // Controller settles on the new sum
        repeat (2) @(posedge clk);
        #1;
    end
    if (phase == PH_PLAY && shown_sum[PLAYER] < BUST_LIMIT && shown_count[PLAYER] < MAX_CARDS) begin
        press_button(BTN_STAND);
    end
    wait_phase(PH_DONE, "the game to end");
    read_hands();
    exp = expected_outcome(shown_sum[PLAYER], shown_sum[HOUSE]);
    assert (outcome == exp) else begin
        $display("mismatch outcome: got 'h%h expected 'h%h", outcome, exp);
        errors++;
    end
    if (shown_sum[PLAYER] > BUST_LIMIT) begin
        assert (shown_count[HOUSE] == 2) else begin
            $display("house drew after the player went bust");
            errors++;
        end
    end else begin
        check_house_play();
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, errors - errors_before);
    end
endtask

task automatic test_reset_state();
    int e0;
    e0 = errors;
    read_hands();
    assert (phase == PH_IDLE) else begin
        $display("mismatch phase: got 'h%h expected 'h%h", phase, PH_IDLE);
        errors++;
    end
    assert (outcome == OC_NONE) else begin
        $display("mismatch outcome: got 'h%h expected 'h%h", outcome, OC_NONE);
        errors++;
    end
    assert (shown_count[PLAYER] == 0 && shown_count[HOUSE] == 0) else begin
        $display("card digits are not blank after reset");
        errors++;
    end
    finish_test("reset state", e0);
endtask

task automatic test_deal();
    int e0;
    e0 = errors;
    deal_game(6'($urandom));
    read_hands();
    for (int h = 0; h < 2; h++) begin
        assert (shown_count[h] == 2 && shown_cards[h][0] != 0 && shown_cards[h][1] != 0) else begin
            $display("hand %0d does not hold two dealt cards", h);
            errors++;
        end
    end
    assert (outcome == OC_NONE) else begin
        $display("mismatch outcome: got 'h%h expected 'h%h", outcome, OC_NONE);
        errors++;
    end
    // Close the game so the next begin is taken
    press_button(BTN_STAND);
    wait_phase(PH_DONE, "the game to end after the deal");
    finish_test("deal", e0);
endtask

task automatic test_stand();
    int e0;
    e0 = errors;
    repeat (2) play_and_check(6'($urandom), 0);
    finish_test("stand", e0);
endtask

task automatic test_hit();
    int e0;
    e0 = errors;
    repeat (2) play_and_check(6'($urandom), HOUSE_STAND);
    finish_test("hit", e0);
endtask

task automatic test_reproducibility();
    int e0;
    int first [2][2];
    logic [5:0] s;
    e0 = errors;
    s  = 6'($urandom);
    for (int run = 0; run < 2; run++) begin
        // Replay runs on from the first game, so only the seed load can repeat the deal
        if (run == 0) begin
            reset_dut();
        end
        deal_game(s);
        read_hands();
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < 2; i++) begin
                if (run == 0) begin
                    first[h][i] = shown_cards[h][i];
                end else begin
                    assert (shown_cards[h][i] == first[h][i]) else begin
                        $display("mismatch hand %0d card %0d: got 'h%h expected 'h%h",
                                 h, i, shown_cards[h][i], first[h][i]);
                        errors++;
                    end
                end
            end
        end
        press_button(BTN_STAND);
        wait_phase(PH_DONE, "the replayed game to end");
    end
    // Random seeds with random hit thresholds
    repeat (4) play_and_check(6'($urandom), 12 + int'($urandom % 6));
    finish_test("reproducibility", e0);
endtask

task automatic test_ignored_buttons();
    int e0;
    int saved [2][MAX_CARDS];
    outcome_t saved_oc;
    e0 = errors;
    reset_dut();
    press_button(BTN_HIT);
    press_button(BTN_STAND);
    repeat (6) @(posedge clk);
    #1;
    read_hands();
    assert (phase == PH_IDLE && outcome == OC_NONE &&
            shown_count[PLAYER] == 0 && shown_count[HOUSE] == 0) else begin
        $display("hit or stand in idle changed the game");
        errors++;
    end
    play_and_check(6'($urandom), 0);
    saved    = shown_cards;
    saved_oc = outcome;
    press_button(BTN_HIT);
    press_button(BTN_STAND);
    repeat (6) @(posedge clk);
    #1;
    read_hands();
    assert (phase == PH_DONE && outcome == saved_oc && shown_cards == saved) else begin
        $display("hit or stand after the game changed the hands or the outcome");
        errors++;
    end
    finish_test("ignored buttons", e0);
endtask

`endif

/* verification/blackjack_tb.sv */
/*
  Testbench for blackjack_top with MAX_CARDS at its default of five.
  Hands are read back from the digits only, one hand per hand_select value.
  Inputs change 1 ns after the rising edge; outputs are read after that.
*/
`timescale 1ns/10ps

module blackjack_tb;
    import blackjack_pkg::*;

    localparam int MAX_CARDS       = 5;
    localparam int CYCLES_PER_CARD = 20;
    localparam int NUM_GAMES       = 12;
    // Longest wait for one phase change, a full table of cards
    localparam int STEP_LIMIT      = 2 * MAX_CARDS * CYCLES_PER_CARD + 50;
    // Buttons and readback add roughly a hundred cycles per game
    localparam int WATCHDOG_CYCLES = NUM_GAMES * (STEP_LIMIT + 100) + 1000;
    localparam int PLAYER          = 0;
    localparam int HOUSE           = 1;
    localparam int BTN_BEGIN       = 0;
    localparam int BTN_HIT         = 1;
    localparam int BTN_STAND       = 2;

    logic       clk;
    logic       rst;
    logic       begin_n;
    logic       hit_n;
    logic       stand_n;
    logic       hand_select;
    logic [5:0] seed;
    phase_t     phase;
    outcome_t   outcome;
    seg_t       hand_seg [6];

    // Decoded hands, index PLAYER or HOUSE
    int shown_cards [2][MAX_CARDS];
    int shown_count [2];
    int shown_sum   [2];
    int errors;
    int tests_run;
    int tests_failed;

    blackjack_top #(.MAX_CARDS(MAX_CARDS)) dut_i (
        .clk, .rst, .begin_n, .hit_n, .stand_n, .hand_select, .seed,
        .phase, .outcome, .hand_seg
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Ends a stuck run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the game never finished", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    `include "blackjack_tests.svh"

    initial begin
        begin_n      = 1'b1;
        hit_n        = 1'b1;
        stand_n      = 1'b1;
        hand_select  = 1'b0;
        seed         = '0;
        rst          = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h3ccd_5977));
        reset_dut();

        test_reset_state();
        test_deal();
        test_stand();
        test_hit();
        test_reproducibility();
        test_ignored_buttons();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verification
logic/blackjack_pkg.sv
logic/card_if.sv
logic/card_source.sv
logic/hand_store.sv
logic/game_ctrl.sv
logic/hand_display.sv
logic/blackjack_top.sv
verification/blackjack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the blackjack testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module blackjack_tb \
    -f compile.f -o blackjack_sim || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/blackjack_sim)"
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && exit 0 || exit 1
